// ==== sim.f ====
src/fpnc_pkg.sv
src/slice_out_if.sv
src/fpnc_fmt_cfg.sv
src/fpnc_fmt_slice.sv
src/fpnc_rr_arb.sv
src/fpnc_opgroup_block.sv
test/fpnc_checker.sv
test/tb_fpnc.sv

// ==== Makefile ====
# Verilator simulation of the operation group

VERILATOR ?= verilator
TOP       ?= tb_fpnc
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ns
FAIL_MSG  ?= Some tests failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_fpnc.sv ====
// Operation group testbench

`timescale 1ns/1ns
`default_nettype none

module tb_fpnc import fpnc_pkg::*; ();

  localparam int RESET_CYCLES  = 8;
  localparam int ACCEPT_LIMIT  = 50;
  localparam int DRAIN_LIMIT   = 400;
  localparam int REFUSE_CYCLES = 20;

  // One table row with a request and its expected result
  typedef struct packed {
    operation_e op;
    fp_format_e fmt;
    operand_t   a;
    operand_t   b;
    operand_t   res;
    status_t    st;
  } vec_t;

  logic       clk_i = 1'b0;
  logic       rst_i;
  logic       cfg_we_i;
  fmt_mask_t  cfg_fmt_en_i;
  operation_e op_i;
  fp_format_e fmt_i;
  operand_t   op_a_i;
  operand_t   op_b_i;
  tag_t       tag_i;
  logic       in_valid_i;
  logic       in_ready_o;
  logic       flush_i;
  operand_t   result_o;
  status_t    status_o;
  tag_t       tag_o;
  logic       out_valid_o;
  logic       out_ready_i;
  logic       busy_o;

  operand_t   exp_result;
  status_t    exp_status;
  vec_t       vec_q [$];
  integer     seed = 63078;
  logic       ready_random;
  int         top_pass = 0;
  int         top_errs = 0;
  int         errs_before;
  int         chk_pass;
  int         chk_errs;
  int         chk_pending;

  fpnc_opgroup_block u_dut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_fmt_en_i (cfg_fmt_en_i),
    .op_i         (op_i),
    .fmt_i        (fmt_i),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .tag_i        (tag_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .flush_i      (flush_i),
    .result_o     (result_o),
    .status_o     (status_o),
    .tag_o        (tag_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .busy_o       (busy_o)
  );

  fpnc_checker u_chk (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .in_valid_i   (in_valid_i),
    .in_ready_i   (in_ready_o),
    .in_tag_i     (tag_i),
    .exp_result_i (exp_result),
    .exp_status_i (exp_status),
    .out_valid_i  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_tag_i    (tag_o),
    .result_i     (result_o),
    .status_i     (status_o),
    .pass_cnt_o   (chk_pass),
    .err_cnt_o    (chk_errs),
    .pending_o    (chk_pending)
  );

  always #50 clk_i = ~clk_i;

  // Output ready about three cycles in four
  always @(posedge clk_i) begin
    if (ready_random) begin
      out_ready_i <= ($random(seed) & 3) != 0;
    end else begin
      out_ready_i <= 1'b0;
    end
  end

  // ---------------------------------------------------------------------
  // Stimulus table
  // ---------------------------------------------------------------------
  task automatic add_vec(input operation_e op, input fp_format_e fmt, input operand_t a,
                         input operand_t b, input operand_t res, input status_t st);
    vec_q.push_back({op, fmt, a, b, res, st});
  endtask

  task automatic build_table();
    // Sign injection with FP16 upper operand bits ignored
    add_vec(SGNJ,  FP32, 32'h3F800000, 32'hC0000000, 32'hBF800000, 5'h00);
    add_vec(SGNJ,  FP16, 32'h00003C00, 32'h0000C000, 32'hFFFFBC00, 5'h00);
    add_vec(SGNJN, FP32, 32'h3F800000, 32'hC0000000, 32'h3F800000, 5'h00);
    add_vec(SGNJN, FP16, 32'h00003C00, 32'h0000C000, 32'hFFFF3C00, 5'h00);
    add_vec(SGNJX, FP32, 32'hBF800000, 32'hC0000000, 32'h3F800000, 5'h00);
    add_vec(SGNJX, FP16, 32'hABCDBC00, 32'h00004000, 32'hFFFFBC00, 5'h00);
    // Ordinary min and max
    add_vec(MIN,   FP32, 32'h3F800000, 32'h40000000, 32'h3F800000, 5'h00);
    add_vec(MIN,   FP16, 32'h00003C00, 32'h00004000, 32'hFFFF3C00, 5'h00);
    add_vec(MAX,   FP32, 32'h3F800000, 32'h40000000, 32'h40000000, 5'h00);
    add_vec(MAX,   FP16, 32'h00003C00, 32'h00004000, 32'hFFFF4000, 5'h00);
    // Signed zeros
    add_vec(MIN,   FP32, 32'h80000000, 32'h00000000, 32'h80000000, 5'h00);
    add_vec(MIN,   FP16, 32'h00008000, 32'h00000000, 32'hFFFF8000, 5'h00);
    add_vec(MAX,   FP32, 32'h80000000, 32'h00000000, 32'h00000000, 5'h00);
    add_vec(MAX,   FP16, 32'h00008000, 32'h00000000, 32'hFFFF0000, 5'h00);
    // Quiet NaN operands
    add_vec(MIN,   FP32, 32'h7FC00000, 32'hC0400000, 32'hC0400000, 5'h00);
    add_vec(MAX,   FP16, 32'h00007E00, 32'h0000C200, 32'hFFFFC200, 5'h00);
    add_vec(MAX,   FP32, 32'h7FC00001, 32'h7FC00002, 32'h7FC00000, 5'h00);
    add_vec(MIN,   FP16, 32'h00007E01, 32'h0000FE00, 32'hFFFF7E00, 5'h00);
    // Signaling NaNs and negative operands
    add_vec(MAX,   FP32, 32'h7F800001, 32'h3F800000, 32'h3F800000, 5'h10);
    add_vec(MIN,   FP16, 32'h00007C01, 32'h00004000, 32'hFFFF4000, 5'h10);
    add_vec(MIN,   FP32, 32'hBF800000, 32'hC0000000, 32'hC0000000, 5'h00);
    add_vec(MAX,   FP16, 32'h00003C00, 32'h0000FD00, 32'hFFFF3C00, 5'h10);
    add_vec(MIN,   FP32, 32'hFF800001, 32'h7FC00000, 32'h7FC00000, 5'h10);
    add_vec(MAX,   FP16, 32'h1234C400, 32'h5678C200, 32'hFFFFC200, 5'h00);
  endtask

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------
  task automatic drive_req(input vec_t v, input tag_t tag);
    op_i       <= v.op;
    fmt_i      <= v.fmt;
    op_a_i     <= v.a;
    op_b_i     <= v.b;
    tag_i      <= tag;
    exp_result <= v.res;
    exp_status <= v.st;
    in_valid_i <= 1'b1;
  endtask

  // Request stays up until in_ready_o or the limit
  task automatic wait_accept(input int max_cycles, output bit acc);
    int n;
    acc = 1'b0;
    n   = 0;
    while (!acc && n < max_cycles) begin
      @(posedge clk_i);
      acc = in_ready_o;
      n++;
    end
    if (acc) begin
      in_valid_i <= 1'b0;
    end
  endtask

  task automatic send_req(input vec_t v, input tag_t tag);
    bit acc;
    drive_req(v, tag);
    wait_accept(ACCEPT_LIMIT, acc);
    if (!acc) begin
      top_errs++;
      in_valid_i <= 1'b0;
      $display("Request with tag %0d was not accepted in time", tag);
    end
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while ((chk_pending != 0 || busy_o) && n < max_cycles);
    if (chk_pending != 0 || busy_o) begin
      top_errs++;
      $display("Timed out with %0d results still missing", chk_pending);
    end
  endtask

  task automatic expect_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      top_errs++;
      $display("ERR %s got 0x%0h expected 0x%0h", sig, got, exp);
    end
  endtask

  // Errors from the testbench and the checker together
  function automatic int error_total();
    return top_errs + chk_errs;
  endfunction

  task automatic end_test(input string name, input int errs_at_start);
    if (error_total() == errs_at_start) begin
      top_pass++;
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s", name);
    end
  endtask

  // ---------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------
  initial begin
    bit accepted;
    rst_i        <= 1'b1;
    cfg_we_i     <= 1'b0;
    cfg_fmt_en_i <= '1;
    op_i         <= SGNJ;
    fmt_i        <= FP32;
    op_a_i       <= '0;
    op_b_i       <= '0;
    tag_i        <= '0;
    in_valid_i   <= 1'b0;
    flush_i      <= 1'b0;
    out_ready_i  <= 1'b0;
    exp_result   <= '0;
    exp_status   <= '0;
    ready_random <= 1'b1;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;

    // Idle after reset with both formats ready
    errs_before = error_total();
    @(posedge clk_i);
    expect_val("out_valid_o", out_valid_o, 0);
    expect_val("busy_o", busy_o, 0);
    expect_val("in_ready_o", in_ready_o, 1);
    fmt_i <= FP16;
    @(posedge clk_i);
    expect_val("in_ready_o", in_ready_o, 1);
    end_test("reset state", errs_before);

    // Whole table in mixed formats under random back-pressure
    errs_before = error_total();
    for (int i = 0; i < vec_q.size(); i++) begin
      send_req(vec_q[i], tag_t'(i));
    end
    wait_drain(DRAIN_LIMIT);
    end_test("table requests", errs_before);

    // FP16 switched off, then back on
    errs_before = error_total();
    cfg_we_i     <= 1'b1;
    cfg_fmt_en_i <= 2'b01;
    @(posedge clk_i);
    cfg_we_i <= 1'b0;
    drive_req(vec_q[9], 8'd64);
    wait_accept(REFUSE_CYCLES, accepted);
    if (accepted) begin
      top_errs++;
      $display("Request accepted while its format was disabled");
    end
    expect_val("out_valid_o", out_valid_o, 0);
    expect_val("busy_o", busy_o, 0);
    cfg_we_i     <= 1'b1;
    cfg_fmt_en_i <= 2'b11;
    @(posedge clk_i);
    cfg_we_i <= 1'b0;
    wait_accept(ACCEPT_LIMIT, accepted);
    if (!accepted) begin
      top_errs++;
      in_valid_i <= 1'b0;
      $display("Request not accepted after its format was enabled again");
    end
    wait_drain(DRAIN_LIMIT);
    end_test("format disable", errs_before);

    // Fill both slices with output stalled, then flush
    errs_before = error_total();
    ready_random <= 1'b0;
    @(posedge clk_i);
    send_req(vec_q[1], 8'd128);
    send_req(vec_q[3], 8'd129);
    send_req(vec_q[0], 8'd130);
    expect_val("busy_o", busy_o, 1);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(posedge clk_i);
    expect_val("busy_o", busy_o, 0);
    expect_val("out_valid_o", out_valid_o, 0);
    ready_random <= 1'b1;
    repeat (REFUSE_CYCLES) @(posedge clk_i);
    expect_val("busy_o", busy_o, 0);
    end_test("flush", errs_before);

    $display("Tests finished: %0d passed, %0d failed",
             top_pass + chk_pass, top_errs + chk_errs);
    if (top_errs + chk_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/fpnc_checker.sv ====
// Operation group result checker

`timescale 1ns/1ns
`default_nettype none

module fpnc_checker import fpnc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     flush_i,
  // Request side, with the values expected for that request
  input  logic     in_valid_i,
  input  logic     in_ready_i,
  input  tag_t     in_tag_i,
  input  operand_t exp_result_i,
  input  status_t  exp_status_i,
  // Result side
  input  logic     out_valid_i,
  input  logic     out_ready_i,
  input  tag_t     out_tag_i,
  input  operand_t result_i,
  input  status_t  status_i,
  // Running totals
  output int       pass_cnt_o,
  output int       err_cnt_o,
  output int       pending_o
);

  typedef enum logic [1:0] {
    TAG_IDLE,
    TAG_PENDING,
    TAG_DONE,
    TAG_FLUSHED
  } tag_state_e;

  // ---------------------------------------------------------------------
  // Scoreboard indexed by tag
  // ---------------------------------------------------------------------
  tag_state_e state_q   [256];
  operand_t   exp_res_q [256];
  status_t    exp_st_q  [256];
  int         pass_cnt;
  int         err_cnt;
  int         pending;
  logic       match;

  always @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 256; i++) begin
        state_q[i] = TAG_IDLE;
      end
      pass_cnt = 0;
      err_cnt  = 0;
      pending  = 0;
    end else begin
      // Result leaving the block
      if (out_valid_i && out_ready_i) begin
        case (state_q[out_tag_i])
          TAG_PENDING: begin
            match = 1'b1;
            if (result_i !== exp_res_q[out_tag_i]) begin
              $display("ERR tag %0d result_o got 0x%08h expected 0x%08h",
                       out_tag_i, result_i, exp_res_q[out_tag_i]);
              match = 1'b0;
            end
            if (status_i !== exp_st_q[out_tag_i]) begin
              $display("ERR tag %0d status_o got 0x%02h expected 0x%02h",
                       out_tag_i, status_i, exp_st_q[out_tag_i]);
              match = 1'b0;
            end
            if (match) begin
              pass_cnt++;
              $display("PASS tag %0d result 0x%08h", out_tag_i, result_i);
            end else begin
              err_cnt++;
            end
            state_q[out_tag_i] = TAG_DONE;
            pending--;
          end
          TAG_DONE: begin
            err_cnt++;
            $display("Tag %0d came out a second time", out_tag_i);
          end
          TAG_FLUSHED: begin
            err_cnt++;
            $display("Tag %0d came out after it was flushed", out_tag_i);
          end
          default: begin
            err_cnt++;
            $display("Tag %0d came out but was never accepted", out_tag_i);
          end
        endcase
      end
      // Everything in flight is dropped by a flush
      if (flush_i) begin
        for (int i = 0; i < 256; i++) begin
          if (state_q[i] == TAG_PENDING) begin
            state_q[i] = TAG_FLUSHED;
            pending--;
          end
        end
      end
      // Request entering the block
      if (in_valid_i && in_ready_i) begin
        if (state_q[in_tag_i] == TAG_PENDING) begin
          err_cnt++;
          $display("Tag %0d accepted again while still in flight", in_tag_i);
        end else begin
          pending++;
        end
        state_q[in_tag_i]   = TAG_PENDING;
        exp_res_q[in_tag_i] = exp_result_i;
        exp_st_q[in_tag_i]  = exp_status_i;
      end
    end
    pass_cnt_o <= pass_cnt;
    err_cnt_o  <= err_cnt;
    pending_o  <= pending;
  end

endmodule

`default_nettype wire

// ==== src/fpnc_opgroup_block.sv ====
// Non-computational operation group

`timescale 1ns/1ns
`default_nettype none

module fpnc_opgroup_block import fpnc_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  // Format enable configuration
  input  logic       cfg_we_i,
  input  fmt_mask_t  cfg_fmt_en_i,
  // Request
  input  operation_e op_i,
  input  fp_format_e fmt_i,
  input  operand_t   op_a_i,
  input  operand_t   op_b_i,
  input  tag_t       tag_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  logic       flush_i,
  // Result
  output operand_t   result_o,
  output status_t    status_o,
  output tag_t       tag_o,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output logic       busy_o
);

  fmt_mask_t fmt_en;
  fmt_mask_t slice_valid, slice_ready, slice_busy;

  slice_out_if fp32_out ();
  slice_out_if fp16_out ();

  fpnc_fmt_cfg u_cfg (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_fmt_en_i (cfg_fmt_en_i),
    .fmt_en_o     (fmt_en)
  );

  // ---------------------------------------------------------------------
  // Dispatch by destination format
  // ---------------------------------------------------------------------
  assign slice_valid[FP32] = in_valid_i & (fmt_i == FP32) & fmt_en[FP32];
  assign slice_valid[FP16] = in_valid_i & (fmt_i == FP16) & fmt_en[FP16];

  // A disabled format never signals ready
  assign in_ready_o = fmt_en[fmt_i] & slice_ready[fmt_i];

  fpnc_fmt_slice #(
    .FMT      (FP32),
    .NUM_PIPE (PIPE_FP32)
  ) u_slice_fp32 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .flush_i    (flush_i),
    .in_valid_i (slice_valid[FP32]),
    .in_ready_o (slice_ready[FP32]),
    .op_i       (op_i),
    .op_a_i     (op_a_i),
    .op_b_i     (op_b_i),
    .tag_i      (tag_i),
    .busy_o     (slice_busy[FP32]),
    .out        (fp32_out)
  );

  fpnc_fmt_slice #(
    .FMT      (FP16),
    .NUM_PIPE (PIPE_FP16)
  ) u_slice_fp16 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .flush_i    (flush_i),
    .in_valid_i (slice_valid[FP16]),
    .in_ready_o (slice_ready[FP16]),
    .op_i       (op_i),
    .op_a_i     (op_a_i),
    .op_b_i     (op_b_i),
    .tag_i      (tag_i),
    .busy_o     (slice_busy[FP16]),
    .out        (fp16_out)
  );

  // ---------------------------------------------------------------------
  // Merge results
  // ---------------------------------------------------------------------
  fpnc_rr_arb u_arb (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .in_fp32     (fp32_out),
    .in_fp16     (fp16_out),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

  assign busy_o = |slice_busy;

endmodule

`default_nettype wire

// ==== src/fpnc_rr_arb.sv ====
// Round-robin output arbiter

`timescale 1ns/1ns
`default_nettype none

module fpnc_rr_arb import fpnc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      flush_i,
  slice_out_if.arb  in_fp32,
  slice_out_if.arb  in_fp16,
  output operand_t  result_o,
  output status_t   status_o,
  output tag_t      tag_o,
  output logic      out_valid_o,
  input  logic      out_ready_i
);

  // Format that wins when both slices are valid
  fp_format_e prio_q;
  logic       gnt_fp32, gnt_fp16;

  // ---------------------------------------------------------------------
  // Grant
  // ---------------------------------------------------------------------
  assign gnt_fp16 = in_fp16.valid & (~in_fp32.valid | (prio_q == FP16));
  assign gnt_fp32 = in_fp32.valid & ~gnt_fp16;

  assign in_fp32.ready = out_ready_i & gnt_fp32;
  assign in_fp16.ready = out_ready_i & gnt_fp16;

  assign out_valid_o = in_fp32.valid | in_fp16.valid;

  // Payload of the granted slice
  assign result_o = gnt_fp16 ? in_fp16.result : in_fp32.result;
  assign status_o = gnt_fp16 ? in_fp16.status : in_fp32.status;
  assign tag_o    = gnt_fp16 ? in_fp16.tag    : in_fp32.tag;

  // ---------------------------------------------------------------------
  // Priority pointer
  // ---------------------------------------------------------------------
  // Moves past the winner only on a transfer
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      prio_q <= FP32;
    end else if (out_valid_o && out_ready_i) begin
      prio_q <= gnt_fp16 ? FP32 : FP16;
    end
  end

endmodule

`default_nettype wire

// ==== src/fpnc_fmt_slice.sv ====
// Sign injection and min/max slice

`timescale 1ns/1ns
`default_nettype none

module fpnc_fmt_slice import fpnc_pkg::*; #(
  parameter fp_format_e FMT      = FP32,
  parameter int         NUM_PIPE = 1
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          flush_i,
  input  logic          in_valid_i,
  output logic          in_ready_o,
  input  operation_e    op_i,
  input  operand_t      op_a_i,
  input  operand_t      op_b_i,
  input  tag_t          tag_i,
  output logic          busy_o,
  slice_out_if.slice    out
);

  // ---------------------------------------------------------------------
  // Operand fields
  // ---------------------------------------------------------------------
  logic [FMT_W[FMT]-1:0] a_f, b_f, res_f;
  logic [FMT_W[FMT]-2:0] a_mag, b_mag;
  logic                  a_sgn, b_sgn;
  logic                  a_nan, b_nan, a_snan, b_snan;
  logic                  a_lt_b;
  operand_t              canon_nan;
  operand_t              res_comb;
  status_t               status_comb;

  // FP16 only looks at the low half
  assign a_f   = op_a_i[FMT_W[FMT]-1:0];
  assign b_f   = op_b_i[FMT_W[FMT]-1:0];
  assign a_sgn = a_f[FMT_W[FMT]-1];
  assign b_sgn = b_f[FMT_W[FMT]-1];
  assign a_mag = a_f[FMT_W[FMT]-2:0];
  assign b_mag = b_f[FMT_W[FMT]-2:0];

  // Exponent all ones with nonzero mantissa
  assign a_nan  = (&a_f[FMT_W[FMT]-2:MAN_W[FMT]]) & (|a_f[MAN_W[FMT]-1:0]);
  assign b_nan  = (&b_f[FMT_W[FMT]-2:MAN_W[FMT]]) & (|b_f[MAN_W[FMT]-1:0]);
  assign a_snan = a_nan & ~a_f[MAN_W[FMT]-1];
  assign b_snan = b_nan & ~b_f[MAN_W[FMT]-1];

  // Signs differ: the negative one is lower, so -0 sorts below +0
  assign a_lt_b = (a_sgn != b_sgn) ? a_sgn :
                  (a_sgn ? (a_mag > b_mag) : (a_mag < b_mag));

  assign canon_nan = (FMT == FP32) ? CANON_NAN32 : operand_t'(CANON_NAN16);

  // ---------------------------------------------------------------------
  // Result selection
  // ---------------------------------------------------------------------
  always_comb begin
    res_f       = a_f;
    status_comb = '0;
    case (op_i)
      SGNJ:  res_f = {b_sgn, a_mag};
      SGNJN: res_f = {~b_sgn, a_mag};
      SGNJX: res_f = {a_sgn ^ b_sgn, a_mag};
      MIN, MAX: begin
        status_comb[NV_BIT] = a_snan | b_snan;
        if (a_nan && b_nan) begin
          res_f = canon_nan[FMT_W[FMT]-1:0];
        end else if (a_nan) begin
          res_f = b_f;
        end else if (b_nan) begin
          res_f = a_f;
        end else if ((op_i == MIN) == a_lt_b) begin
          res_f = a_f;
        end else begin
          res_f = b_f;
        end
      end
      default: res_f = a_f;
    endcase
    // Narrow results are NaN-boxed
    res_comb                = '1;
    res_comb[FMT_W[FMT]-1:0] = res_f;
  end

  // ---------------------------------------------------------------------
  // Elastic pipeline
  // ---------------------------------------------------------------------
  logic     [NUM_PIPE-1:0] stage_valid;
  operand_t [NUM_PIPE-1:0] stage_res;
  status_t  [NUM_PIPE-1:0] stage_status;
  tag_t     [NUM_PIPE-1:0] stage_tag;

  // Index 0 is the slice input, NUM_PIPE the slice output
  logic     [NUM_PIPE:0]   chain_valid;
  operand_t [NUM_PIPE:0]   chain_res;
  status_t  [NUM_PIPE:0]   chain_status;
  tag_t     [NUM_PIPE:0]   chain_tag;
  logic     [NUM_PIPE:0]   stage_ready;

  assign chain_valid  = {stage_valid, in_valid_i};
  assign chain_res    = {stage_res, res_comb};
  assign chain_status = {stage_status, status_comb};
  assign chain_tag    = {stage_tag, tag_i};

  // A stage takes data when empty or when its content moves on
  always_comb begin
    stage_ready[NUM_PIPE] = out.ready;
    for (int i = NUM_PIPE - 1; i >= 0; i--) begin
      stage_ready[i] = ~stage_valid[i] | stage_ready[i+1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      stage_valid <= '0;
    end else begin
      for (int i = 0; i < NUM_PIPE; i++) begin
        if (stage_ready[i]) begin
          stage_valid[i] <= chain_valid[i];
        end
      end
    end
  end

  // Payload only moves with a valid item
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_PIPE; i++) begin
      if (stage_ready[i] && chain_valid[i]) begin
        stage_res[i]    <= chain_res[i];
        stage_status[i] <= chain_status[i];
        stage_tag[i]    <= chain_tag[i];
      end
    end
  end

  assign in_ready_o = stage_ready[0] & ~flush_i;
  assign busy_o     = |stage_valid;

  // Hide the last stage while it is being flushed
  assign out.valid  = chain_valid[NUM_PIPE] & ~flush_i;
  assign out.result = chain_res[NUM_PIPE];
  assign out.status = chain_status[NUM_PIPE];
  assign out.tag    = chain_tag[NUM_PIPE];

endmodule

`default_nettype wire

// ==== src/fpnc_fmt_cfg.sv ====
// Format enable register

`timescale 1ns/1ns
`default_nettype none

module fpnc_fmt_cfg import fpnc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      cfg_we_i,
  input  fmt_mask_t cfg_fmt_en_i,
  output fmt_mask_t fmt_en_o
);

  // ---------------------------------------------------------------------
  // Enable bits, one per format
  // ---------------------------------------------------------------------
  fmt_mask_t fmt_en_q;

  // All formats come up enabled
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fmt_en_q <= '1;
    end else if (cfg_we_i) begin
      fmt_en_q <= cfg_fmt_en_i;
    end
  end

  assign fmt_en_o = fmt_en_q;

endmodule

`default_nettype wire

// ==== src/slice_out_if.sv ====
// Slice result channel

`timescale 1ns/1ns
`default_nettype none

interface slice_out_if import fpnc_pkg::*; ();

  operand_t result;
  status_t  status;
  tag_t     tag;
  logic     valid;
  logic     ready;

  // Producer side, one format slice
  modport slice (
    output result, status, tag, valid,
    input  ready
  );

  // Consumer side, the output arbiter
  modport arb (
    input  result, status, tag, valid,
    output ready
  );

endinterface

`default_nettype wire

// ==== src/fpnc_pkg.sv ====
// Non-computational FPU operation group package

`default_nettype none

package fpnc_pkg;

  // ---------------------------------------------------------------------
  // Widths and counts
  // ---------------------------------------------------------------------
  localparam int unsigned WIDTH    = 32;
  localparam int unsigned NUM_FMTS = 2;

  // Destination formats
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  // Operations handled by this group
  typedef enum logic [2:0] {
    SGNJ,
    SGNJN,
    SGNJX,
    MIN,
    MAX
  } operation_e;

  typedef logic [WIDTH-1:0]    operand_t;
  typedef logic [7:0]          tag_t;
  // NV, DZ, OF, UF, NX from MSB down
  typedef logic [4:0]          status_t;
  typedef logic [NUM_FMTS-1:0] fmt_mask_t;

  // Invalid-operation flag position in status_t
  localparam int unsigned NV_BIT = 4;

  // ---------------------------------------------------------------------
  // Per-format layout, indexed by fp_format_e
  // ---------------------------------------------------------------------
  // Total bits of the format
  localparam int unsigned FMT_W [NUM_FMTS] = '{32, 16};
  // Mantissa bits, quiet bit is the top one
  localparam int unsigned MAN_W [NUM_FMTS] = '{23, 10};

  // Pipeline registers per slice
  localparam int unsigned PIPE_FP32 = 1;
  localparam int unsigned PIPE_FP16 = 2;

  // Canonical quiet NaNs
  localparam operand_t    CANON_NAN32 = 32'h7FC0_0000;
  localparam logic [15:0] CANON_NAN16 = 16'h7E00;

endpackage

`default_nettype wire
